//--- design/mc_params.svh
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// Host side
`define MC_NUM_HOSTS        2
`define MC_HOST_DAT_W       32
// Word address is bank, row, then word column
`define MC_HOST_ADR_W       23

// Device geometry
`define MC_BANK_W           2
`define MC_ROW_W            13
`define MC_COL_W            9
`define MC_DQ_W             16

// Device timing in sdram_clk cycles
`define MC_CAS_LATENCY      2
`define MC_T_RCD            2
`define MC_T_RC_TAIL        4
`define MC_T_RFC            7
`define MC_INIT_WAIT        100
`define MC_REFRESH_INTERVAL 390

// READ command edge to host acknowledge
`define MC_READ_DELAY       (`MC_CAS_LATENCY + 3)

`endif

//--- design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

   // Encoded as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_LOAD_MODE    = 3'b000,
      CMD_AUTO_REFRESH = 3'b001,
      CMD_PRECHARGE    = 3'b010,
      CMD_ACTIVE       = 3'b011,
      CMD_WRITE        = 3'b100,
      CMD_READ         = 3'b101,
      CMD_NOP          = 3'b111
   } sdram_cmd_e;

   typedef enum logic [3:0] {
      ST_INIT_WAIT,
      ST_INIT_PRE,
      ST_INIT_REF,
      ST_LOAD_MODE,
      ST_IDLE,
      ST_REFRESH,
      ST_ACTIVATE,
      ST_ACCESS,
      ST_WRITE_BEAT2,
      ST_RECOVER
   } mc_state_e;

endpackage

`default_nettype wire

//--- design/host_pkg.sv
`default_nettype none
`include "mc_params.svh"

package host_pkg;

   typedef logic [$clog2(`MC_NUM_HOSTS)-1:0] host_id_t;
   typedef logic [`MC_HOST_ADR_W-1:0]        host_adr_t;
   typedef logic [`MC_HOST_DAT_W-1:0]        host_dat_t;
   typedef logic [`MC_HOST_DAT_W/8-1:0]      host_sel_t;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } access_op_e;

endpackage

`default_nettype wire

//--- design/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module port_arbiter (
   input  wire                       sdram_clk,
   input  wire                       sdram_rst,
   input  wire [`MC_NUM_HOSTS-1:0]   host_req_i,
   input  wire                       start_i,
   input  wire host_pkg::host_id_t   start_id_i,
   input  wire [`MC_NUM_HOSTS-1:0]   host_ack_i,
   output logic                      pick_valid_o,
   output host_pkg::host_id_t        pick_id_o
);

   // One bit per host with an access in flight
   logic [`MC_NUM_HOSTS-1:0] busy;
   logic [`MC_NUM_HOSTS-1:0] avail;

   assign avail = host_req_i & ~busy;

   // Lowest index wins
   always_comb begin
      pick_valid_o = |avail;
      pick_id_o    = '0;
      for (int i = `MC_NUM_HOSTS - 1; i >= 0; i--) begin
         if (avail[i]) begin
            pick_id_o = host_pkg::host_id_t'(i);
         end
      end
   end

   // Busy from start until the edge after the acknowledge
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < `MC_NUM_HOSTS; i++) begin
            if (start_i && (start_id_i == host_pkg::host_id_t'(i))) begin
               busy[i] <= 1'b1;
            end else if (host_ack_i[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/sdram_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_cmd_fsm (
   input  wire                                         sdram_clk,
   input  wire                                         sdram_rst,
   input  wire                                         pick_valid_i,
   input  wire host_pkg::host_id_t                     pick_id_i,
   input  wire [`MC_NUM_HOSTS-1:0]                     host_we_i,
   input  wire host_pkg::host_adr_t [`MC_NUM_HOSTS-1:0] host_adr_i,
   output logic                                        start_o,
   output host_pkg::host_id_t                          start_id_o,
   output logic                                        wr_beat1_o,
   output host_pkg::host_id_t                          wr_id_o,
   output logic                                        rd_issue_o,
   output host_pkg::host_id_t                          rd_id_o,
   output sdram_pkg::sdram_cmd_e                       cmd_o,
   output logic [`MC_BANK_W-1:0]                       ba_o,
   output logic [`MC_ROW_W-1:0]                        a_o
);

   localparam int CNT_W  = $clog2(`MC_INIT_WAIT);
   localparam int REF_W  = $clog2(`MC_REFRESH_INTERVAL);
   localparam int WCOL_W = `MC_HOST_ADR_W - `MC_BANK_W - `MC_ROW_W;

   // CAS latency in a[6:4], burst length two in a[2:0]
   localparam logic [`MC_ROW_W-1:0] MODE_WORD =
      {(`MC_ROW_W - 7)'(0), 3'(`MC_CAS_LATENCY), 1'b0, 3'b001};
   localparam logic [`MC_ROW_W-1:0] A10 = `MC_ROW_W'(1 << 10);

   sdram_pkg::mc_state_e  state;
   logic [CNT_W-1:0]      cnt;
   logic                  second_ref;
   logic [REF_W-1:0]      ref_timer;
   logic                  ref_pending;
   logic                  ref_issue;
   logic                  take;
   host_pkg::access_op_e  op_q;
   host_pkg::host_id_t    id_q;
   host_pkg::host_adr_t   adr_q;
   host_pkg::host_adr_t   pick_adr;
   logic [`MC_ROW_W-1:0]  col_addr;

   assign pick_adr  = host_adr_i[pick_id_i];
   assign ref_issue = (state == sdram_pkg::ST_IDLE) && ref_pending;
   assign take      = (state == sdram_pkg::ST_IDLE) && !ref_pending && pick_valid_i;

   assign start_id_o = id_q;
   assign wr_id_o    = id_q;
   assign rd_id_o    = id_q;
   assign wr_beat1_o = (state == sdram_pkg::ST_ACCESS) && (op_q == host_pkg::OP_WRITE);
   assign rd_issue_o = (state == sdram_pkg::ST_ACCESS) && (op_q == host_pkg::OP_READ);

   // Word column plus zero, a[10] high for auto-precharge
   always_comb begin
      col_addr                 = '0;
      col_addr[`MC_COL_W-1:0]  = {adr_q[WCOL_W-1:0], 1'b0};
      col_addr[10]             = 1'b1;
   end

   always_ff @(posedge sdram_clk) begin
      if (take) begin
         adr_q <= pick_adr;
      end
   end

   // Refresh request timer
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_timer   <= REF_W'(`MC_REFRESH_INTERVAL - 1);
         ref_pending <= 1'b0;
      end else begin
         if (ref_timer == '0) begin
            ref_timer   <= REF_W'(`MC_REFRESH_INTERVAL - 1);
            ref_pending <= 1'b1;
         end else begin
            ref_timer <= ref_timer - 1'b1;
            if (ref_issue) begin
               ref_pending <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state      <= sdram_pkg::ST_INIT_WAIT;
         cnt        <= CNT_W'(`MC_INIT_WAIT - 1);
         second_ref <= 1'b0;
         cmd_o      <= sdram_pkg::CMD_NOP;
         ba_o       <= '0;
         a_o        <= '0;
         start_o    <= 1'b0;
         op_q       <= host_pkg::OP_READ;
         id_q       <= '0;
      end else begin
         cmd_o   <= sdram_pkg::CMD_NOP;
         start_o <= 1'b0;
         case (state)
            sdram_pkg::ST_INIT_WAIT: begin
               if (cnt == '0) begin
                  cmd_o <= sdram_pkg::CMD_PRECHARGE;
                  a_o   <= A10;
                  state <= sdram_pkg::ST_INIT_PRE;
                  cnt   <= CNT_W'(`MC_T_RC_TAIL - 1);
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            sdram_pkg::ST_INIT_PRE: begin
               if (cnt == '0) begin
                  cmd_o      <= sdram_pkg::CMD_AUTO_REFRESH;
                  state      <= sdram_pkg::ST_INIT_REF;
                  cnt        <= CNT_W'(`MC_T_RFC - 1);
                  second_ref <= 1'b0;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            sdram_pkg::ST_INIT_REF: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else if (!second_ref) begin
                  cmd_o      <= sdram_pkg::CMD_AUTO_REFRESH;
                  cnt        <= CNT_W'(`MC_T_RFC - 1);
                  second_ref <= 1'b1;
               end else begin
                  cmd_o <= sdram_pkg::CMD_LOAD_MODE;
                  ba_o  <= '0;
                  a_o   <= MODE_WORD;
                  state <= sdram_pkg::ST_LOAD_MODE;
                  // tMRD fits in the tRCD count
                  cnt   <= CNT_W'(`MC_T_RCD - 1);
               end
            end
            sdram_pkg::ST_LOAD_MODE, sdram_pkg::ST_REFRESH, sdram_pkg::ST_RECOVER: begin
               if (cnt == '0) begin
                  state <= sdram_pkg::ST_IDLE;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            sdram_pkg::ST_IDLE: begin
               if (ref_pending) begin
                  cmd_o <= sdram_pkg::CMD_AUTO_REFRESH;
                  state <= sdram_pkg::ST_REFRESH;
                  cnt   <= CNT_W'(`MC_T_RFC - 1);
               end else if (pick_valid_i) begin
                  cmd_o   <= sdram_pkg::CMD_ACTIVE;
                  ba_o    <= pick_adr[`MC_HOST_ADR_W-1 -: `MC_BANK_W];
                  a_o     <= pick_adr[WCOL_W +: `MC_ROW_W];
                  op_q    <= host_we_i[pick_id_i] ? host_pkg::OP_WRITE : host_pkg::OP_READ;
                  id_q    <= pick_id_i;
                  start_o <= 1'b1;
                  state   <= sdram_pkg::ST_ACTIVATE;
                  cnt     <= CNT_W'(`MC_T_RCD - 2);
               end
            end
            sdram_pkg::ST_ACTIVATE: begin
               if (cnt == '0) begin
                  state <= sdram_pkg::ST_ACCESS;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            sdram_pkg::ST_ACCESS: begin
               ba_o <= adr_q[`MC_HOST_ADR_W-1 -: `MC_BANK_W];
               a_o  <= col_addr;
               if (op_q == host_pkg::OP_WRITE) begin
                  cmd_o <= sdram_pkg::CMD_WRITE;
                  state <= sdram_pkg::ST_WRITE_BEAT2;
               end else begin
                  cmd_o <= sdram_pkg::CMD_READ;
                  state <= sdram_pkg::ST_RECOVER;
                  cnt   <= CNT_W'(`MC_T_RC_TAIL - 1);
               end
            end
            sdram_pkg::ST_WRITE_BEAT2: begin
               state <= sdram_pkg::ST_RECOVER;
               cnt   <= CNT_W'(`MC_T_RC_TAIL - 1);
            end
            default: begin
               state <= sdram_pkg::ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/sdram_data_path.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_data_path (
   input  wire                                          sdram_clk,
   input  wire                                          sdram_rst,
   input  wire                                          wr_beat1_i,
   input  wire host_pkg::host_id_t                      wr_id_i,
   input  wire                                          rd_issue_i,
   input  wire host_pkg::host_id_t                      rd_id_i,
   input  wire host_pkg::host_dat_t [`MC_NUM_HOSTS-1:0] host_dat_i,
   input  wire host_pkg::host_sel_t [`MC_NUM_HOSTS-1:0] host_sel_i,
   input  wire [`MC_DQ_W-1:0]                           dq_i,
   output logic [`MC_DQ_W-1:0]                          dq_o,
   output logic [`MC_DQ_W/8-1:0]                        dqm_o,
   output logic                                         dq_oe_o,
   output logic [`MC_NUM_HOSTS-1:0]                     host_ack_o,
   output host_pkg::host_dat_t                          host_dat_o
);

   localparam int RD_STAGES = `MC_READ_DELAY;
   localparam int DQM_W     = `MC_DQ_W / 8;

   host_pkg::host_dat_t       wr_dat;
   host_pkg::host_sel_t       wr_sel;
   logic [`MC_DQ_W-1:0]       lo_beat;
   logic [DQM_W-1:0]          lo_dqm;
   logic                      beat2_pend;
   host_pkg::host_id_t        beat2_id;
   logic [`MC_DQ_W-1:0]       dq_r1;
   logic [`MC_DQ_W-1:0]       dq_r2;
   logic [RD_STAGES-1:0]      rd_vld;
   host_pkg::host_id_t        rd_tag [RD_STAGES];
   logic [`MC_NUM_HOSTS-1:0]  ack_d;

   assign wr_dat = host_dat_i[wr_id_i];
   assign wr_sel = host_sel_i[wr_id_i];

   // Write ack rides with beat two, read ack leaves the delay line
   always_comb begin
      ack_d = '0;
      if (beat2_pend) begin
         ack_d[beat2_id] = 1'b1;
      end
      if (rd_vld[RD_STAGES-1]) begin
         ack_d[rd_tag[RD_STAGES-1]] = 1'b1;
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         dq_oe_o    <= 1'b0;
         dqm_o      <= '1;
         beat2_pend <= 1'b0;
         beat2_id   <= '0;
         rd_vld     <= '0;
         host_ack_o <= '0;
      end else begin
         beat2_pend <= wr_beat1_i;
         dq_oe_o    <= wr_beat1_i | beat2_pend;
         rd_vld     <= {rd_vld[RD_STAGES-2:0], rd_issue_i};
         host_ack_o <= ack_d;
         if (wr_beat1_i) begin
            beat2_id <= wr_id_i;
         end
         // Masks are active high on the pins
         if (wr_beat1_i) begin
            dqm_o <= ~wr_sel[2*DQM_W-1:DQM_W];
         end else if (beat2_pend) begin
            dqm_o <= lo_dqm;
         end else begin
            dqm_o <= '0;
         end
      end
   end

   always_ff @(posedge sdram_clk) begin
      dq_r1     <= dq_i;
      dq_r2     <= dq_r1;
      rd_tag[0] <= rd_id_i;
      for (int i = 1; i < RD_STAGES; i++) begin
         rd_tag[i] <= rd_tag[i-1];
      end
      // Upper half goes out first
      if (wr_beat1_i) begin
         dq_o    <= wr_dat[`MC_HOST_DAT_W-1 -: `MC_DQ_W];
         lo_beat <= wr_dat[`MC_DQ_W-1:0];
         lo_dqm  <= ~wr_sel[DQM_W-1:0];
      end else if (beat2_pend) begin
         dq_o <= lo_beat;
      end
      if (rd_vld[RD_STAGES-1]) begin
         host_dat_o <= {dq_r2, dq_r1};
      end
   end

endmodule

`default_nettype wire

//--- design/sdram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_ctrl_top (
   input  wire                                          sdram_clk,
   input  wire                                          sdram_rst,
   input  wire [`MC_NUM_HOSTS-1:0]                      host_req_i,
   input  wire [`MC_NUM_HOSTS-1:0]                      host_we_i,
   input  wire host_pkg::host_adr_t [`MC_NUM_HOSTS-1:0] host_adr_i,
   input  wire host_pkg::host_dat_t [`MC_NUM_HOSTS-1:0] host_dat_i,
   input  wire host_pkg::host_sel_t [`MC_NUM_HOSTS-1:0] host_sel_i,
   input  wire [`MC_DQ_W-1:0]                           dq_i,
   output logic [`MC_NUM_HOSTS-1:0]                     host_ack_o,
   output host_pkg::host_dat_t                          host_dat_o,
   output logic                                         ras_n_o,
   output logic                                         cas_n_o,
   output logic                                         we_n_o,
   output logic [`MC_BANK_W-1:0]                        ba_o,
   output logic [`MC_ROW_W-1:0]                         a_o,
   output logic [`MC_DQ_W-1:0]                          dq_o,
   output logic [`MC_DQ_W/8-1:0]                        dqm_o,
   output logic                                         dq_oe_o
);

   logic                   pick_valid;
   host_pkg::host_id_t     pick_id;
   logic                   start;
   host_pkg::host_id_t     start_id;
   logic                   wr_beat1;
   host_pkg::host_id_t     wr_id;
   logic                   rd_issue;
   host_pkg::host_id_t     rd_id;
   sdram_pkg::sdram_cmd_e  cmd;

   assign {ras_n_o, cas_n_o, we_n_o} = cmd;

   port_arbiter u_arb (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .host_req_i   (host_req_i),
      .start_i      (start),
      .start_id_i   (start_id),
      .host_ack_i   (host_ack_o),
      .pick_valid_o (pick_valid),
      .pick_id_o    (pick_id)
   );

   sdram_cmd_fsm u_fsm (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .pick_valid_i (pick_valid),
      .pick_id_i    (pick_id),
      .host_we_i    (host_we_i),
      .host_adr_i   (host_adr_i),
      .start_o      (start),
      .start_id_o   (start_id),
      .wr_beat1_o   (wr_beat1),
      .wr_id_o      (wr_id),
      .rd_issue_o   (rd_issue),
      .rd_id_o      (rd_id),
      .cmd_o        (cmd),
      .ba_o         (ba_o),
      .a_o          (a_o)
   );

   sdram_data_path u_dp (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .wr_beat1_i   (wr_beat1),
      .wr_id_i      (wr_id),
      .rd_issue_i   (rd_issue),
      .rd_id_i      (rd_id),
      .host_dat_i   (host_dat_i),
      .host_sel_i   (host_sel_i),
      .dq_i         (dq_i),
      .dq_o         (dq_o),
      .dqm_o        (dqm_o),
      .dq_oe_o      (dq_oe_o),
      .host_ack_o   (host_ack_o),
      .host_dat_o   (host_dat_o)
   );

endmodule

`default_nettype wire

//--- tests/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_model (
   input  wire                     sdram_clk,
   input  wire                     ras_n_i,
   input  wire                     cas_n_i,
   input  wire                     we_n_i,
   input  wire [`MC_BANK_W-1:0]    ba_i,
   input  wire [`MC_ROW_W-1:0]     a_i,
   input  wire [`MC_DQ_W-1:0]      dq_i,
   input  wire [`MC_DQ_W/8-1:0]    dqm_i,
   output logic [`MC_DQ_W-1:0]     dq_o = '0
);

   localparam int CL    = `MC_CAS_LATENCY;
   localparam int KEY_W = `MC_BANK_W + `MC_ROW_W + `MC_COL_W;

   // One 16-bit word per bank, row and column
   logic [`MC_DQ_W-1:0]  mem [logic [KEY_W-1:0]];
   logic [`MC_ROW_W-1:0] open_row [1 << `MC_BANK_W];
   logic                 wr_pend = 1'b0;
   logic [KEY_W-1:0]     wr_key;
   logic [CL-1:0]        rd_v = '0;
   logic [KEY_W-1:0]     rd_key [CL];
   logic [KEY_W-1:0]     cur_key;
   sdram_pkg::sdram_cmd_e cmd;

   assign cmd     = sdram_pkg::sdram_cmd_e'({ras_n_i, cas_n_i, we_n_i});
   assign cur_key = {ba_i, open_row[ba_i], a_i[`MC_COL_W-1:0]};

   function automatic void store(input logic [KEY_W-1:0] key, input logic [15:0] d,
                                 input logic [1:0] m);
      logic [15:0] old;
      old = mem.exists(key) ? mem[key] : 16'h0;
      mem[key] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
   endfunction

   function automatic logic [15:0] fetch(input logic [KEY_W-1:0] key);
      return mem.exists(key) ? mem[key] : 16'h0;
   endfunction

   always @(posedge sdram_clk) begin
      wr_pend <= 1'b0;
      if (wr_pend) begin
         store(wr_key, dq_i, dqm_i);
      end
      // Beat one then beat two, CAS latency after the READ
      if (rd_v[CL-2]) begin
         dq_o <= fetch(rd_key[CL-2]);
      end
      if (rd_v[CL-1]) begin
         dq_o <= fetch(rd_key[CL-1] + 1'b1);
      end
      rd_v      <= {rd_v[CL-2:0], cmd == sdram_pkg::CMD_READ};
      rd_key[0] <= cur_key;
      for (int i = 1; i < CL; i++) begin
         rd_key[i] <= rd_key[i-1];
      end
      if (cmd == sdram_pkg::CMD_ACTIVE) begin
         open_row[ba_i] <= a_i;
      end else if (cmd == sdram_pkg::CMD_WRITE) begin
         store(cur_key, dq_i, dqm_i);
         wr_pend <= 1'b1;
         wr_key  <= cur_key + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- tests/sdram_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_ctrl_assert (
   input wire                      sdram_clk,
   input wire                      sdram_rst,
   input wire                      ras_n_o,
   input wire                      cas_n_o,
   input wire                      we_n_o,
   input wire                      dq_oe_o,
   input wire [`MC_NUM_HOSTS-1:0]  host_ack_o
);

   logic [2:0]             cmd;
   logic [`MC_T_RCD-2:0]   act_hist;

   assign cmd = {ras_n_o, cas_n_o, we_n_o};

   // Recent ACTIVE commands
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         act_hist <= '0;
      end else begin
         act_hist <= (`MC_T_RCD-1)'((act_hist << 1) | (cmd == sdram_pkg::CMD_ACTIVE));
      end
   end

   nop_after_active: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (|act_hist) |-> (cmd == sdram_pkg::CMD_NOP))
      else $error("command issued inside tRCD after ACTIVE");

   oe_with_write: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      dq_oe_o |-> (cmd == sdram_pkg::CMD_WRITE || $past(cmd) == sdram_pkg::CMD_WRITE))
      else $error("dq_oe high outside a write burst");

   ack_onehot: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      $onehot0(host_ack_o))
      else $error("more than one host acknowledged");

endmodule

`default_nettype wire

//--- tests/sdram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_params.svh"

module sdram_ctrl_tb;

   localparam int NH          = `MC_NUM_HOSTS;
   localparam int N_RANDOM    = 200;
   localparam int N_DIRECTED  = 5;
   localparam int CYCLE_LIMIT = (N_RANDOM + N_DIRECTED) * 40 + 500;
   localparam int REF_GAP_MAX = `MC_REFRESH_INTERVAL + 20;

   logic                                sdram_clk;
   logic                                sdram_rst;
   logic [NH-1:0]                       host_req;
   logic [NH-1:0]                       host_we;
   host_pkg::host_adr_t [NH-1:0]        host_adr;
   host_pkg::host_dat_t [NH-1:0]        host_dat;
   host_pkg::host_sel_t [NH-1:0]        host_sel;
   logic [NH-1:0]                       host_ack;
   host_pkg::host_dat_t                 host_dat_rd;
   logic                                ras_n;
   logic                                cas_n;
   logic                                we_n;
   logic                                dq_oe;
   logic [`MC_BANK_W-1:0]               ba;
   logic [`MC_ROW_W-1:0]                a;
   logic [`MC_DQ_W-1:0]                 dq_to_mem;
   wire  [`MC_DQ_W-1:0]                 dq_bus;
   logic [`MC_DQ_W-1:0]                 dq_from_mem;
   logic [`MC_DQ_W/8-1:0]               dqm;
   sdram_pkg::sdram_cmd_e               cmd;

   int unsigned          rng_state = 43655;
   int                   mismatches = 0;
   int                   errors = 0;
   int                   cycle = 0;
   int                   init_step = 0;
   bit                   mode_loaded = 0;
   int                   last_ref = 0;
   int                   ref_count = 0;
   int                   read_times [$];
   bit                   pend_we [NH][$];
   int                   ack_cycle [NH];
   int                   req_total [NH];
   int                   ack_total [NH];
   int                   lat;
   host_pkg::host_dat_t  ref_mem [NH*16];
   bit                   rnd_we [NH][N_RANDOM];
   int                   rnd_idx [NH][N_RANDOM];
   host_pkg::host_dat_t  rnd_dat [NH][N_RANDOM];
   host_pkg::host_sel_t  rnd_sel [NH][N_RANDOM];
   int                   rnd_cnt [NH];

   assign cmd = sdram_pkg::sdram_cmd_e'({ras_n, cas_n, we_n});

   // Controller drives the bus only while dq_oe is high
   assign dq_bus = dq_oe ? dq_to_mem : 'z;

   sdram_ctrl_top uut (
      .sdram_clk (sdram_clk), .sdram_rst (sdram_rst),
      .host_req_i (host_req), .host_we_i (host_we), .host_adr_i (host_adr),
      .host_dat_i (host_dat), .host_sel_i (host_sel), .dq_i (dq_from_mem),
      .host_ack_o (host_ack), .host_dat_o (host_dat_rd),
      .ras_n_o (ras_n), .cas_n_o (cas_n), .we_n_o (we_n), .ba_o (ba), .a_o (a),
      .dq_o (dq_to_mem), .dqm_o (dqm), .dq_oe_o (dq_oe)
   );

   sdram_model u_mem (
      .sdram_clk (sdram_clk), .ras_n_i (ras_n), .cas_n_i (cas_n), .we_n_i (we_n),
      .ba_i (ba), .a_i (a), .dq_i (dq_bus), .dqm_i (dqm), .dq_o (dq_from_mem)
   );

   bind sdram_ctrl_top sdram_ctrl_assert u_assert (
      .sdram_clk (sdram_clk), .sdram_rst (sdram_rst), .ras_n_o (ras_n_o),
      .cas_n_o (cas_n_o), .we_n_o (we_n_o), .dq_oe_o (dq_oe_o), .host_ack_o (host_ack_o)
   );

   function automatic int unsigned lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state >> 8;
   endfunction

   // Host bit sits in both row and column so the hosts never share a word
   function automatic host_pkg::host_adr_t make_adr(input int h, input int idx);
      logic [3:0] i;
      i = 4'(idx);
      return {i[1:0], i[3:2], 10'd0, 1'(h), i, 1'(h), 3'b101};
   endfunction

   function automatic host_pkg::host_dat_t merge_bytes(input host_pkg::host_dat_t old,
         input host_pkg::host_dat_t d, input host_pkg::host_sel_t sel);
      host_pkg::host_dat_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) r[8*b +: 8] = d[8*b +: 8];
      end
      return r;
   endfunction

   task automatic run_access(input int h, input bit we, input int idx,
         input host_pkg::host_dat_t dat, input host_pkg::host_sel_t sel, input string name);
      host_pkg::host_dat_t expect_dat;
      expect_dat = ref_mem[h*16 + idx];
      pend_we[h].push_back(we);
      req_total[h]++;
      host_we[h]  = we;
      host_adr[h] = make_adr(h, idx);
      host_dat[h] = dat;
      host_sel[h] = sel;
      host_req[h] = 1'b1;
      @(negedge sdram_clk);
      while (!host_ack[h]) @(negedge sdram_clk);
      if (we) begin
         ref_mem[h*16 + idx] = merge_bytes(ref_mem[h*16 + idx], dat, sel);
      end else begin
         assert (host_dat_rd == expect_dat) else begin
            mismatches++;
            $display("mismatch %s: expected %h actual %h", name, expect_dat, host_dat_rd);
         end
      end
   endtask

   task automatic host_traffic(input int h);
      for (int i = 0; i < rnd_cnt[h]; i++) begin
         run_access(h, rnd_we[h][i], rnd_idx[h][i], rnd_dat[h][i], rnd_sel[h][i], "random");
      end
      host_req[h] = 1'b0;
   endtask

   initial begin
      sdram_clk = 1'b0;
      forever #5 sdram_clk = ~sdram_clk;
   end

   // Bus monitor on the falling edge where outputs are settled
   always @(negedge sdram_clk) begin
      cycle++;
      if (!sdram_rst && !mode_loaded && cmd != sdram_pkg::CMD_NOP) begin
         case (init_step)
            0: assert (cmd == sdram_pkg::CMD_PRECHARGE && a[10]) else begin
                  errors++;
                  $display("init: first command was %s, not precharge all", cmd.name());
               end
            1, 2: assert (cmd == sdram_pkg::CMD_AUTO_REFRESH) else begin
                  errors++;
                  $display("init: got %s where an auto refresh belongs", cmd.name());
               end
            default: assert (cmd == sdram_pkg::CMD_LOAD_MODE && a == 13'h021) else begin
                  mismatches++;
                  $display("mismatch init_mode: expected %s 021 actual %s %h",
                           "LOAD_MODE", cmd.name(), a);
               end
         endcase
         init_step++;
         if (init_step == 4) begin
            mode_loaded = 1'b1;
            last_ref    = cycle;
         end
      end else if (mode_loaded && cmd == sdram_pkg::CMD_AUTO_REFRESH) begin
         assert (cycle - last_ref <= REF_GAP_MAX) else begin
            errors++;
            $display("refresh gap of %0d cycles is too long", cycle - last_ref);
         end
         last_ref = cycle;
         ref_count++;
      end
      if (cmd == sdram_pkg::CMD_READ) read_times.push_back(cycle);
      for (int h = 0; h < NH; h++) begin
         if (host_ack[h]) begin
            ack_cycle[h] = cycle;
            ack_total[h]++;
            assert (pend_we[h].size() > 0) else begin
               errors++;
               $display("host %0d acknowledged with no open request", h);
            end
            if (pend_we[h].size() > 0 && !pend_we[h].pop_front()) begin
               lat = (read_times.size() > 0) ? cycle - read_times.pop_front() : -1;
               assert (lat == `MC_READ_DELAY) else begin
                  mismatches++;
                  $display("mismatch read_latency: expected %0d actual %0d",
                           `MC_READ_DELAY, lat);
               end
            end
         end
      end
      if (cycle > CYCLE_LIMIT) begin
         errors++;
         $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
         $display("errors: %0d mismatches, %0d other", mismatches, errors);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      sdram_rst = 1'b1;
      host_req  = '0;
      host_we   = '0;
      host_adr  = '0;
      host_dat  = '0;
      host_sel  = '0;
      for (int i = 0; i < NH*16; i++) ref_mem[i] = '0;
      repeat (16) @(negedge sdram_clk);
      sdram_rst = 1'b0;
      while (!mode_loaded) @(negedge sdram_clk);

      // Write, partial write, read back
      run_access(0, 1'b1, 3, 32'h1234_5678, 4'b1111, "write_full");
      run_access(0, 1'b1, 3, 32'hAABB_CCDD, 4'b0101, "write_partial");
      run_access(0, 1'b0, 3, '0, '0, "readback");
      assert (host_dat_rd == 32'h12BB_56DD) else begin
         mismatches++;
         $display("mismatch readback_merge: expected %h actual %h", 32'h12BB_56DD, host_dat_rd);
      end
      host_req[0] = 1'b0;
      repeat (20) @(negedge sdram_clk);

      // Same-cycle requests from both hosts
      fork
         begin
            run_access(0, 1'b0, 3, '0, '0, "priority_h0");
            host_req[0] = 1'b0;
         end
         begin
            run_access(1, 1'b0, 5, '0, '0, "priority_h1");
            host_req[1] = 1'b0;
         end
      join
      // Monitor has logged the last acknowledge by the next falling edge
      @(negedge sdram_clk);
      assert (ack_cycle[0] < ack_cycle[1]) else begin
         errors++;
         $display("host 1 was acknowledged before host 0");
      end

      rnd_cnt = '{default: 0};
      for (int n = 0; n < N_RANDOM; n++) begin
         int h;
         h = lcg_next() % NH;
         rnd_we[h][rnd_cnt[h]]  = 1'(lcg_next() % 2);
         rnd_idx[h][rnd_cnt[h]] = lcg_next() % 16;
         rnd_dat[h][rnd_cnt[h]] = {16'(lcg_next()), 16'(lcg_next())};
         rnd_sel[h][rnd_cnt[h]] = 4'(lcg_next());
         rnd_cnt[h]++;
      end
      fork
         host_traffic(0);
         host_traffic(1);
      join

      repeat (20) @(negedge sdram_clk);
      for (int h = 0; h < NH; h++) begin
         assert (ack_total[h] == req_total[h]) else begin
            errors++;
            $display("host %0d got %0d acknowledges for %0d requests",
                     h, ack_total[h], req_total[h]);
         end
      end
      assert (ref_count > 0 && cycle - last_ref <= REF_GAP_MAX) else begin
         errors++;
         $display("no auto refresh in the last %0d cycles", cycle - last_ref);
      end
      $display("errors: %0d mismatches, %0d other", mismatches, errors);
      if (mismatches + errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/sdram_pkg.sv
design/host_pkg.sv
design/port_arbiter.sv
design/sdram_cmd_fsm.sv
design/sdram_data_path.sv
design/sdram_ctrl_top.sv
tests/sdram_model.sv
tests/sdram_ctrl_assert.sv
tests/sdram_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module sdram_ctrl_tb -o sim_bin
./obj_dir/sim_bin | tee sim.log

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
exit 0
